//--- build.f
+incdir+design
design/disc_pkg.sv
design/hysteresis_trigger.sv
design/gate_timer.sv
design/sample_discriminator.sv
design/disc_regs.sv
design/disc_top.sv
tb/disc_clock_gen.sv
tb/disc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile the discriminator testbench with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module disc_tb \
  --Mdir obj_dir -o disc_sim

./obj_dir/disc_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished without failures"

//--- tb/disc_tb.sv
/* testbench for the ADC sample discriminator; a reference model of the
   gating rules runs beside the DUT and concurrent assertions compare them */

`timescale 1ns/1ps
`include "disc_config.svh"

module disc_tb;
  import disc_pkg::*;

  localparam int WAIT_LIMIT = 50;
  localparam axil_addr_t REG_ADDR [5] = '{`DISC_REG_THRESH0, 5'h04, `DISC_REG_HOLD,
                                          `DISC_REG_SEL, `DISC_REG_DISABLE};
  localparam axil_data_t REG_MASK [5] = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_3F3F,
                                          32'h0000_000F, 32'h0000_0003};

  logic                                 adc_clk;
  logic                                 rst_n;
  axil_req_t                            axil_req;
  axil_rsp_t                            axil_rsp;
  adc_word_t    [`DISC_CHANNELS-1:0]    adc_data_in;
  logic         [`DISC_DIG_CHANNELS-1:0] dig_trigger;
  adc_word_t    [`DISC_CHANNELS-1:0]    adc_data_out;
  tstamp_word_t [`DISC_CHANNELS-1:0]    tstamp_out;

  disc_cfg_t                 model_cfg;    // configuration the DUT was last given
  tstamp_t                   cycle_count;  // cycles since reset was released
  logic [`DISC_CHANNELS-1:0] hyst_state;
  hold_t                     remain [`DISC_CHANNELS];
  logic [`DISC_CHANNELS-1:0] open_win;     // window still open after the last valid word
  logic [`DISC_CHANNELS-1:0] exp_valid;
  logic [`DISC_CHANNELS-1:0] exp_ts_valid;
  sample_t [`DISC_CHANNELS-1:0][`DISC_PARALLEL-1:0] exp_samples;
  tstamp_t                   exp_tstamp;
  int                        errors = 0;
  int                        timeouts = 0;

  disc_clock_gen u_clk (.adc_clk, .rst_n);

  disc_top UUT (
    .adc_clk,
    .rst_n,
    .axil_req,
    .axil_rsp,
    .adc_data_in,
    .dig_trigger,
    .adc_data_out,
    .tstamp_out
  );

  task automatic report_error(input string msg);
    errors++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic timeout_fail(input string what);
    timeouts++;
    $display("gave up waiting: %s", what);
  endtask

  // *******************************************************************
  // reference model
  // *******************************************************************
  function automatic logic hyst_next(input adc_word_t w, input thresholds_t t, input logic cur);
    logic any_above;
    logic all_below;
    any_above = 1'b0;
    all_below = 1'b1;
    for (int i = 0; i < `DISC_PARALLEL; i++) begin
      if ($signed(w.samples[i]) > $signed(t.high)) any_above = 1'b1;
      if (!($signed(w.samples[i]) < $signed(t.low))) all_below = 1'b0;
    end
    if (!w.valid) return cur;
    if (any_above) return 1'b1;
    if (all_below) return 1'b0;
    return cur;
  endfunction

  always @(posedge adc_clk) begin
    if (!rst_n) cycle_count <= '0;
    else cycle_count <= cycle_count + 1'b1;
  end

  always @(posedge adc_clk) begin : ref_model
    logic [`DISC_CHANNELS-1:0]                    comp;
    logic [`DISC_DIG_CHANNELS+`DISC_CHANNELS-1:0] src;
    logic                                         trig;
    logic                                         win;
    logic                                         first;
    if (!rst_n) begin
      hyst_state = '0;
      open_win   = '0;
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) remain[ch] = '0;
      exp_valid    <= '0;
      exp_ts_valid <= '0;
    end else begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        comp[ch] = hyst_next(adc_data_in[ch], model_cfg.thresholds[ch], hyst_state[ch]);
      end
      src = {dig_trigger, comp};  // comparators first, then digital triggers
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        trig  = src[model_cfg.sel[ch]];
        win   = 1'b0;
        first = 1'b0;
        if (adc_data_in[ch].valid) begin
          hyst_state[ch] = comp[ch];
          if (trig) begin
            win        = 1'b1;
            first      = !open_win[ch];
            remain[ch] = model_cfg.hold[ch];
          end else if (remain[ch] != '0) begin
            win        = 1'b1;  // one of the hold words
            remain[ch] = remain[ch] - 1'b1;
          end
          open_win[ch] = trig || (remain[ch] != '0);
        end
        exp_valid[ch]    <= adc_data_in[ch].valid && (model_cfg.disable_mask[ch] || win);
        exp_ts_valid[ch] <= adc_data_in[ch].valid && !model_cfg.disable_mask[ch] && first;
        exp_samples[ch]  <= adc_data_in[ch].samples;
      end
      exp_tstamp <= cycle_count;
    end
  end

  for (genvar ch = 0; ch < `DISC_CHANNELS; ch++) begin : g_check
    assert property (@(posedge adc_clk) disable iff (!rst_n)
      adc_data_out[ch].valid == exp_valid[ch])
      else report_error($sformatf("channel %0d output valid differs from the model", ch));
    assert property (@(posedge adc_clk) disable iff (!rst_n)
      adc_data_out[ch].valid |-> adc_data_out[ch].samples == exp_samples[ch])
      else report_error($sformatf("channel %0d kept word differs from its input", ch));
    assert property (@(posedge adc_clk) disable iff (!rst_n)
      tstamp_out[ch].valid == exp_ts_valid[ch])
      else report_error($sformatf("channel %0d timestamp valid differs from the model", ch));
    assert property (@(posedge adc_clk) disable iff (!rst_n)
      tstamp_out[ch].valid |-> tstamp_out[ch].tstamp == exp_tstamp)
      else report_error($sformatf("channel %0d timestamp value is wrong", ch));
  end

  // *******************************************************************
  // AXI4-Lite access
  // *******************************************************************
  task automatic write_reg(input axil_addr_t addr, input axil_data_t data, input axil_strb_t strb);
    int t;
    @(posedge adc_clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= strb;
    for (t = 0; t < WAIT_LIMIT; t++) begin
      @(negedge adc_clk);
      if (axil_rsp.awready && axil_rsp.wready) break;
    end
    if (t == WAIT_LIMIT) timeout_fail("write address and data were never accepted");
    @(posedge adc_clk);  // handshake edge
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    for (t = 0; t < WAIT_LIMIT; t++) begin
      @(negedge adc_clk);
      if (axil_rsp.bvalid) break;
    end
    if (t == WAIT_LIMIT) timeout_fail("no write response arrived");
    assert (axil_rsp.bresp == `DISC_AXIL_RESP_OKAY)
      else report_error($sformatf("write to 0x%02h answered bresp %0d", addr, axil_rsp.bresp));
    // the response has to stay up while bready is still low
    repeat ($urandom % 3) begin
      @(negedge adc_clk);
      assert (axil_rsp.bvalid)
        else report_error($sformatf("write response to 0x%02h dropped before bready", addr));
    end
    @(posedge adc_clk);
    axil_req.bready <= 1'b1;
    @(posedge adc_clk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic read_reg(input axil_addr_t addr, output axil_data_t data);
    int t;
    @(posedge adc_clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    for (t = 0; t < WAIT_LIMIT; t++) begin
      @(negedge adc_clk);
      if (axil_rsp.arready) break;
    end
    if (t == WAIT_LIMIT) timeout_fail("read address was never accepted");
    @(posedge adc_clk);
    axil_req.arvalid <= 1'b0;
    for (t = 0; t < WAIT_LIMIT; t++) begin
      @(negedge adc_clk);
      if (axil_rsp.rvalid) break;
    end
    if (t == WAIT_LIMIT) timeout_fail("no read data arrived");
    data = axil_rsp.rdata;
    assert (axil_rsp.rresp == `DISC_AXIL_RESP_OKAY)
      else report_error($sformatf("read of 0x%02h answered rresp %0d", addr, axil_rsp.rresp));
    // read data must hold still until rready is seen
    repeat ($urandom % 3) begin
      @(negedge adc_clk);
      assert (axil_rsp.rvalid && axil_rsp.rdata == data)
        else report_error($sformatf("read of 0x%02h dropped or changed before rready", addr));
    end
    @(posedge adc_clk);
    axil_req.rready <= 1'b1;
    @(posedge adc_clk);
    axil_req.rready <= 1'b0;
  endtask

  function automatic disc_cfg_t make_cfg(input hold_t h0, input hold_t h1, input sel_t s0,
                                         input sel_t s1, input logic [1:0] mask);
    disc_cfg_t c;
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      c.thresholds[ch].high = 16'sd1000;
      c.thresholds[ch].low  = -16'sd1000;
    end
    c.hold         = {h1, h0};
    c.sel          = {s1, s0};
    c.disable_mask = mask;
    return c;
  endfunction

  // data must be idle while this runs because the model only picks up the change afterwards
  task automatic write_cfg(input disc_cfg_t c);
    write_reg(`DISC_REG_THRESH0, axil_data_t'(c.thresholds[0]), 4'hF);
    write_reg(5'h04, axil_data_t'(c.thresholds[1]), 4'hF);
    write_reg(`DISC_REG_HOLD, {18'b0, c.hold[1], 2'b0, c.hold[0]}, 4'hF);
    write_reg(`DISC_REG_SEL, {28'b0, c.sel[1], c.sel[0]}, 4'hF);
    write_reg(`DISC_REG_DISABLE, {30'b0, c.disable_mask}, 4'hF);
    model_cfg <= c;
  endtask

  // *******************************************************************
  // stimulus
  // *******************************************************************
  function automatic adc_word_t gen_word(input int set_div);
    adc_word_t w;
    int        hit;
    w.valid = ($urandom % 8) != 0;
    for (int i = 0; i < `DISC_PARALLEL; i++) begin
      w.samples[i] = sample_t'(int'($urandom % 1801) - 900);  // between the thresholds
    end
    hit = int'($urandom % `DISC_PARALLEL);
    if ($urandom % set_div == 0) begin
      w.samples[hit] = sample_t'(1001 + int'($urandom % 20000));
    end else if ($urandom % 5 == 0) begin
      for (int i = 0; i < `DISC_PARALLEL; i++) begin
        w.samples[i] = sample_t'(-1001 - int'($urandom % 20000));
      end
    end else if ($urandom % 5 == 0) begin
      w.samples[hit] = sample_t'(-1001 - int'($urandom % 20000));  // one low sample holds
    end
    return w;
  endfunction

  task automatic stream(input int words, input int set_div, input bit toggle_dig);
    for (int i = 0; i < words; i++) begin
      @(posedge adc_clk);
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) adc_data_in[ch] <= gen_word(set_div);
      if (toggle_dig && ($urandom % 6 == 0)) begin
        dig_trigger <= dig_trigger ^ (2'b01 << ($urandom % `DISC_DIG_CHANNELS));
      end
    end
    @(posedge adc_clk);
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) adc_data_in[ch].valid <= 1'b0;
  endtask

  // open windows are run out under the old hold before a new one is loaded
  task automatic apply_cfg(input disc_cfg_t c);
    disc_cfg_t quiet;
    quiet     = model_cfg;
    quiet.sel = {sel_t'(2), sel_t'(2)};
    @(posedge adc_clk);
    dig_trigger <= '0;
    write_cfg(quiet);
    stream(80, 6, 1'b0);
    write_cfg(c);
  endtask

  task automatic check_registers();
    axil_data_t d;
    axil_data_t old;
    axil_data_t rd;
    for (int i = 0; i < 5; i++) begin
      d = $urandom;
      write_reg(REG_ADDR[i], d, 4'hF);
      read_reg(REG_ADDR[i], rd);
      assert (rd == (d & REG_MASK[i]))
        else report_error($sformatf("register 0x%02h read 0x%08h after writing 0x%08h",
                                    REG_ADDR[i], rd, d));
    end
    // partial write keeps the bytes whose strobe is low
    read_reg(`DISC_REG_THRESH0, old);
    d = $urandom;
    write_reg(`DISC_REG_THRESH0, d, 4'b0101);
    read_reg(`DISC_REG_THRESH0, rd);
    assert (rd == ((old & 32'hFF00_FF00) | (d & 32'h00FF_00FF)))
      else report_error($sformatf("strobed write gave 0x%08h", rd));
    for (int a = 5'h14; a <= 5'h1C; a += 4) begin
      write_reg(axil_addr_t'(a), $urandom, 4'hF);
      read_reg(axil_addr_t'(a), rd);
      assert (rd == '0) else report_error($sformatf("unmapped 0x%02h read 0x%08h", a, rd));
    end
  endtask

  task automatic wait_for_reset();
    int t;
    for (t = 0; t < WAIT_LIMIT && rst_n !== 1'b1; t++) @(negedge adc_clk);
    if (rst_n !== 1'b1) timeout_fail("reset was never released");
  endtask

  initial begin : stimulus
    void'($urandom(32'h23c106d2));
    axil_req    <= '0;
    adc_data_in <= '0;
    dig_trigger <= '0;
    model_cfg   <= make_cfg(6'd0, 6'd0, 2'd0, 2'd1, 2'b00);
    wait_for_reset();
    assert (axil_rsp.awready && axil_rsp.wready && axil_rsp.arready &&
            !axil_rsp.bvalid && !axil_rsp.rvalid)
      else report_error("AXI4-Lite handshake signals wrong after reset");

    check_registers();
    write_cfg(make_cfg(6'd0, 6'd0, 2'd0, 2'd1, 2'b00));

    apply_cfg(make_cfg(6'd0, 6'd0, 2'd0, 2'd1, 2'b11));  // both channels bypassed
    stream(100, 6, 1'b0);
    apply_cfg(make_cfg(6'd0, 6'd0, 2'd0, 2'd1, 2'b10));
    stream(100, 6, 1'b0);

    apply_cfg(make_cfg(6'd0, 6'd0, 2'd0, 2'd1, 2'b00));  // plain hysteresis gating
    stream(300, 6, 1'b0);

    repeat (4) begin
      apply_cfg(make_cfg(hold_t'($urandom % 24), hold_t'($urandom % 24), 2'd0, 2'd1, 2'b00));
      stream(300, 30, 1'b0);  // sparse triggers so the hold tail shows
    end

    // cross-channel and digital trigger sources
    apply_cfg(make_cfg(6'd3, 6'd5, 2'd1, 2'd2, 2'b00));
    stream(300, 10, 1'b1);
    apply_cfg(make_cfg(6'd0, 6'd2, 2'd3, 2'd0, 2'b00));
    stream(300, 10, 1'b1);

    repeat (3) @(posedge adc_clk);
    $display("checks finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- tb/disc_clock_gen.sv
/* clock and reset for the discriminator testbench
   100 ns clock period, reset held low for the first 16 rising edges */

`timescale 1ns/1ps

module disc_clock_gen (
  output logic adc_clk,
  output logic rst_n
);

  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  initial begin
    rst_n <= 1'b0;
    repeat (16) @(posedge adc_clk);
    rst_n <= 1'b1;  // the DUT sees reset on the first 16 edges
  end

endmodule

//--- design/disc_top.sv
/* top level of the ADC sample discriminator
   the register block feeds its configuration straight into the data path */

`timescale 1ns/1ps
`include "disc_config.svh"

module disc_top (
  input  logic                                         adc_clk,
  input  logic                                         rst_n,
  input  disc_pkg::axil_req_t                          axil_req,
  output disc_pkg::axil_rsp_t                          axil_rsp,
  input  disc_pkg::adc_word_t    [`DISC_CHANNELS-1:0]  adc_data_in,
  input  logic [`DISC_DIG_CHANNELS-1:0]                dig_trigger,
  output disc_pkg::adc_word_t    [`DISC_CHANNELS-1:0]  adc_data_out,
  output disc_pkg::tstamp_word_t [`DISC_CHANNELS-1:0]  tstamp_out
);
  import disc_pkg::*;

  disc_cfg_t cfg;  // takes effect the cycle after a write

  disc_regs u_regs (
    .adc_clk,
    .rst_n,
    .axil_req,
    .axil_rsp,
    .cfg
  );

  sample_discriminator u_disc (
    .adc_clk,
    .rst_n,
    .cfg,
    .data_in     (adc_data_in),
    .dig_trigger,
    .data_out    (adc_data_out),
    .tstamp_out
  );

endmodule

//--- design/disc_regs.sv
/* AXI4-Lite slave holding the discriminator configuration
   a write needs address and data in the same cycle; unmapped reads return zero */

`timescale 1ns/1ps
`include "disc_config.svh"

module disc_regs (
  input  logic                adc_clk,
  input  logic                rst_n,
  input  disc_pkg::axil_req_t axil_req,
  output disc_pkg::axil_rsp_t axil_rsp,
  output disc_pkg::disc_cfg_t cfg
);
  import disc_pkg::*;

  logic       wr_hs;
  logic       rd_hs;
  logic       bvalid;
  logic       rvalid;
  axil_data_t rdata;
  axil_data_t wr_word;  // register contents after the strobed write

  // *******************************************************************
  // register image, shared by the read path and the strobe merge
  // *******************************************************************
  function automatic axil_data_t reg_image(input axil_addr_t addr, input disc_cfg_t c);
    axil_data_t img;
    img = '0;
    for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
      if (addr == axil_addr_t'(`DISC_REG_THRESH0 + 4 * ch)) img = c.thresholds[ch];
      if (addr == `DISC_REG_HOLD) img[8*ch +: `DISC_TIMER_BITS] = c.hold[ch];
      if (addr == `DISC_REG_SEL) img[`DISC_SEL_BITS*ch +: `DISC_SEL_BITS] = c.sel[ch];
    end
    if (addr == `DISC_REG_DISABLE) img[`DISC_CHANNELS-1:0] = c.disable_mask;
    return img;
  endfunction

  function automatic axil_data_t merge_strobe(input axil_data_t old_word,
                                              input axil_data_t new_word,
                                              input axil_strb_t strb);
    axil_data_t res;
    res = old_word;
    for (int b = 0; b < $bits(axil_strb_t); b++) begin
      if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  assign wr_hs   = axil_req.awvalid & axil_req.wvalid & ~bvalid;
  assign rd_hs   = axil_req.arvalid & ~rvalid;
  assign wr_word = merge_strobe(reg_image(axil_req.awaddr, cfg), axil_req.wdata,
                                axil_req.wstrb);

  // *******************************************************************
  // configuration registers
  // *******************************************************************
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        cfg.thresholds[ch].high <= 16'sh7FFF;  // trigger can never set
        cfg.thresholds[ch].low  <= 16'sh8000;
        cfg.hold[ch]            <= '0;
        cfg.sel[ch]             <= sel_t'(ch);  // own comparator
      end
      cfg.disable_mask <= '0;
    end else if (wr_hs) begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        if (axil_req.awaddr == axil_addr_t'(`DISC_REG_THRESH0 + 4 * ch))
          cfg.thresholds[ch] <= wr_word;
        if (axil_req.awaddr == `DISC_REG_HOLD)
          cfg.hold[ch] <= wr_word[8*ch +: `DISC_TIMER_BITS];
        if (axil_req.awaddr == `DISC_REG_SEL)
          cfg.sel[ch] <= wr_word[`DISC_SEL_BITS*ch +: `DISC_SEL_BITS];
      end
      if (axil_req.awaddr == `DISC_REG_DISABLE)
        cfg.disable_mask <= wr_word[`DISC_CHANNELS-1:0];
    end
  end

  // response channels, each held until the master takes it
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_hs) bvalid <= 1'b1;
      else if (axil_req.bready) bvalid <= 1'b0;
      if (rd_hs) rvalid <= 1'b1;
      else if (axil_req.rready) rvalid <= 1'b0;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (rd_hs) rdata <= reg_image(axil_req.araddr, cfg);
  end

  always_comb begin
    axil_rsp.awready = ~bvalid;
    axil_rsp.wready  = ~bvalid;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.bresp   = `DISC_AXIL_RESP_OKAY;
    axil_rsp.arready = ~rvalid;
    axil_rsp.rvalid  = rvalid;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = `DISC_AXIL_RESP_OKAY;
  end

  assert property (@(posedge adc_clk) disable iff (!rst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else $error("write response withdrawn before bready");

  assert property (@(posedge adc_clk) disable iff (!rst_n)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
    else $error("read data withdrawn or changed before rready");

endmodule

//--- design/sample_discriminator.sv
/* per-channel trigger selection, gating and timestamping of ADC words
   output appears one cycle after input; disabled channels pass everything */

`timescale 1ns/1ps
`include "disc_config.svh"

module sample_discriminator (
  input  logic                                       adc_clk,
  input  logic                                       rst_n,
  input  disc_pkg::disc_cfg_t                        cfg,
  input  disc_pkg::adc_word_t  [`DISC_CHANNELS-1:0]  data_in,
  input  logic [`DISC_DIG_CHANNELS-1:0]              dig_trigger,
  output disc_pkg::adc_word_t  [`DISC_CHANNELS-1:0]  data_out,
  output disc_pkg::tstamp_word_t [`DISC_CHANNELS-1:0] tstamp_out
);
  import disc_pkg::*;

  logic [`DISC_CHANNELS-1:0]                    comp_trig;
  logic [`DISC_DIG_CHANNELS+`DISC_CHANNELS-1:0] trig_src;  // indexed by sel_t
  logic [`DISC_CHANNELS-1:0]                    window;
  logic [`DISC_CHANNELS-1:0]                    start;
  logic [`DISC_CHANNELS-1:0]                    out_valid;
  logic [`DISC_CHANNELS-1:0]                    ts_valid;
  sample_t [`DISC_CHANNELS-1:0][`DISC_PARALLEL-1:0] out_samples;
  tstamp_t                                      sample_count;
  tstamp_t                                      ts_value;

  assign trig_src = {dig_trigger, comp_trig};

  // *******************************************************************
  // per-channel comparator and window
  // *******************************************************************
  genvar ch;
  generate
    for (ch = 0; ch < `DISC_CHANNELS; ch++) begin : g_chan
      hysteresis_trigger u_trig (
        .adc_clk,
        .rst_n,
        .data_in    (data_in[ch]),
        .thresholds (cfg.thresholds[ch]),
        .trigger    (comp_trig[ch])
      );

      gate_timer u_gate (
        .adc_clk,
        .rst_n,
        .advance (data_in[ch].valid),
        .trigger (trig_src[cfg.sel[ch]]),
        .hold    (cfg.hold[ch]),
        .window  (window[ch]),
        .start   (start[ch])
      );

      assign data_out[ch].valid     = out_valid[ch];
      assign data_out[ch].samples   = out_samples[ch];
      assign tstamp_out[ch].valid   = ts_valid[ch];
      assign tstamp_out[ch].tstamp  = ts_value;

      assert property (@(posedge adc_clk) disable iff (!rst_n)
        tstamp_out[ch].valid |-> data_out[ch].valid)
        else $error("timestamp on channel %0d without a kept word", ch);
    end
  endgenerate

  // *******************************************************************
  // output registers and sample counter
  // *******************************************************************
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      out_valid    <= '0;
      ts_valid     <= '0;
      sample_count <= '0;
    end else begin
      out_valid    <= {data_in[1].valid, data_in[0].valid} & (cfg.disable_mask | window);
      ts_valid     <= {data_in[1].valid, data_in[0].valid} & ~cfg.disable_mask & start;
      sample_count <= sample_count + 1'b1;
    end
  end

  always_ff @(posedge adc_clk) begin
    for (int c = 0; c < `DISC_CHANNELS; c++) begin
      out_samples[c] <= data_in[c].samples;
    end
    ts_value <= sample_count;  // counter value when the word entered
  end

endmodule

//--- design/gate_timer.sv
/* window control for one channel; the window follows the trigger and is
   stretched by hold more valid words, start marks its first word */

`timescale 1ns/1ps

module gate_timer (
  input  logic            adc_clk,
  input  logic            rst_n,
  input  logic            advance,
  input  logic            trigger,
  input  disc_pkg::hold_t hold,
  output logic            window,
  output logic            start
);
  import disc_pkg::*;

  typedef enum logic [1:0] {
    idle,
    triggered,
    holding
  } gate_state_t;

  gate_state_t state;
  gate_state_t state_next;
  hold_t       hold_cnt;       // words kept since the trigger fell
  hold_t       hold_cnt_next;
  hold_t       hold_cnt_inc;

  assign hold_cnt_inc = hold_cnt + 1'b1;

  // *******************************************************************
  // next state, evaluated for the word at the input
  // *******************************************************************
  always_comb begin
    state_next    = state;
    hold_cnt_next = hold_cnt;
    window        = 1'b0;
    if (trigger) begin
      window        = 1'b1;
      state_next    = triggered;
      hold_cnt_next = '0;
    end else begin
      case (state)
        triggered, holding: begin
          if (hold_cnt < hold) begin
            window        = 1'b1;
            hold_cnt_next = hold_cnt_inc;
            state_next    = holding;
            if (hold_cnt_inc == hold) begin  // last held word
              state_next    = idle;
              hold_cnt_next = '0;
            end
          end else begin
            state_next    = idle;  // hold of 0, window ends with the trigger
            hold_cnt_next = '0;
          end
        end
        default: ;
      endcase
    end
  end

  // a window only opens from idle, a retrigger while holding extends it
  assign start = advance & trigger & (state == idle);

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      state    <= idle;
      hold_cnt <= '0;
    end else if (advance) begin
      state    <= state_next;
      hold_cnt <= hold_cnt_next;
    end
  end

  assert property (@(posedge adc_clk) disable iff (!rst_n) hold_cnt <= hold)
    else $error("hold counter ran past the programmed hold");

endmodule

//--- design/hysteresis_trigger.sv
/* hysteresis comparator for one channel; sets when any sample of a word is
   above high, clears when every sample is below low, holds otherwise */

`timescale 1ns/1ps
`include "disc_config.svh"

module hysteresis_trigger (
  input  logic                  adc_clk,
  input  logic                  rst_n,
  input  disc_pkg::adc_word_t   data_in,
  input  disc_pkg::thresholds_t thresholds,
  output logic                  trigger
);

  logic any_above;
  logic all_below;
  logic state;

  // samples and thresholds are two's complement
  always_comb begin
    any_above = 1'b0;
    all_below = 1'b1;
    for (int i = 0; i < `DISC_PARALLEL; i++) begin
      if ($signed(data_in.samples[i]) > $signed(thresholds.high)) begin
        any_above = 1'b1;
      end
      if (!($signed(data_in.samples[i]) < $signed(thresholds.low))) begin
        all_below = 1'b0;
      end
    end
  end

  // next state, so the word that crosses the threshold triggers itself
  always_comb begin
    trigger = state;
    if (data_in.valid) begin
      if (any_above) begin
        trigger = 1'b1;
      end else if (all_below) begin
        trigger = 1'b0;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      state <= 1'b0;
    end else begin
      state <= trigger;  // unchanged on invalid words
    end
  end

endmodule

//--- design/disc_pkg.sv
/* types shared by the discriminator, its register block and the testbench
   compile this package before any module that imports it */

`include "disc_config.svh"

package disc_pkg;

  typedef logic signed [`DISC_SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [`DISC_TIMER_BITS-1:0]          hold_t;
  typedef logic [`DISC_SEL_BITS-1:0]            sel_t;
  typedef logic [`DISC_TSTAMP_WIDTH-1:0]        tstamp_t;

  typedef logic [`DISC_AXIL_ADDR_WIDTH-1:0]     axil_addr_t;
  typedef logic [`DISC_AXIL_DATA_WIDTH-1:0]     axil_data_t;
  typedef logic [`DISC_AXIL_DATA_WIDTH/8-1:0]   axil_strb_t;
  typedef logic [1:0]                           axil_resp_t;

  // high sits in the upper half, matching the threshold register layout
  typedef struct packed {
    sample_t high;
    sample_t low;
  } thresholds_t;

  typedef struct packed {
    logic                            valid;
    sample_t [`DISC_PARALLEL-1:0]    samples;  // sample 0 in the low bits
  } adc_word_t;

  typedef struct packed {
    logic    valid;
    tstamp_t tstamp;
  } tstamp_word_t;

  typedef struct packed {
    thresholds_t [`DISC_CHANNELS-1:0] thresholds;
    hold_t       [`DISC_CHANNELS-1:0] hold;
    sel_t        [`DISC_CHANNELS-1:0] sel;
    logic        [`DISC_CHANNELS-1:0] disable_mask;
  } disc_cfg_t;

  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rsp_t;

endpackage

//--- design/disc_config.svh
/* sizes, widths and register offsets of the ADC sample discriminator
   included by the package and by every module that needs a size */

`ifndef DISC_CONFIG_SVH
`define DISC_CONFIG_SVH

// data path
`define DISC_CHANNELS       2
`define DISC_DIG_CHANNELS   2
`define DISC_PARALLEL       2
`define DISC_SAMPLE_WIDTH   16
`define DISC_TIMER_BITS     6
`define DISC_TSTAMP_WIDTH   32
`define DISC_SEL_BITS       2   // channel comparators first, then the digital triggers

// AXI4-Lite register map (byte offsets)
`define DISC_AXIL_ADDR_WIDTH 5
`define DISC_AXIL_DATA_WIDTH 32
`define DISC_AXIL_RESP_OKAY  2'b00
`define DISC_REG_THRESH0     5'h00  // ch1 follows 4 bytes later
`define DISC_REG_HOLD        5'h08
`define DISC_REG_SEL         5'h0C
`define DISC_REG_DISABLE     5'h10

`endif
